//--- Bender.yml
package:
  name: block_relay

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/block_relay_pkg.sv
      - logic/sample_fifo.sv
      - logic/block_sequencer.sv
      - logic/uart_word_tx.sv
      - logic/relay_regs.sv
      - logic/block_relay_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/block_relay_tb.sv

//--- bench/block_relay_tb.sv
// testbench for block_relay_top; assumes BR_BAUD_DIV is even and at least 2
`include "block_relay_defs.svh"

module block_relay_tb import block_relay_pkg::*;;

	localparam int MID_LEN = 2;
	localparam int NUM_ROWS = 5;

	// length to write, expected readback and a flag to write again during drain
	typedef struct packed {
		logic [15:0] len_wr;
		logic [15:0] len_exp;
		logic        mid_wr;
	} row_t;

	logic        clk_sys;
	logic        rst_n;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	sample_t     in_smp;
	logic        in_rdy;
	logic        uart_txd;

	row_t        rows [0:NUM_ROWS-1];
	logic [15:0] exp_q [$];
	logic [31:0] lcg_state;
	logic        beat_pend;
	logic [14:0] done_cnt;
	int          sends_left;
	int          taken_cnt;
	int          words_rx;
	int          words_exp;
	int          cycle_cnt;
	int          cycle_limit;

	block_relay_top u_dut (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp),
		.in_smp   (in_smp),
		.in_rdy   (in_rdy),
		.uart_txd (uart_txd)
	);

	initial clk_sys = 1'b0;
	always #20 clk_sys = ~clk_sys;

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("[ERROR] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
			$display("*** FAILED ***");
			$fatal(1, "stopping on first error");
		end
	endtask

	// one wishbone classic cycle, held until ack
	task automatic bus_access(input logic we, input logic [1:0] adr, input logic [15:0] wdata,
		output logic [15:0] rdata);
		@(negedge clk_sys);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = wdata;
		do @(negedge clk_sys); while (wb_rsp.ack !== 1'b1);
		rdata  = wb_rsp.dat;
		wb_req = '0;
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [15:0] wdata);
		logic [15:0] unused;
		bus_access(1'b1, adr, wdata, unused);
	endtask

	task automatic read_reg(input logic [1:0] adr, output logic [15:0] rdata);
		bus_access(1'b0, adr, 16'h0000, rdata);
	endtask

	// ------------------------------------------------------------
	// sample driver and uart decoder
	// ------------------------------------------------------------

	// a beat counts once the rising edge between two falling edges took it
	always @(negedge clk_sys) begin
		if (rst_n) begin
			if (beat_pend) begin
				exp_q.push_back(in_smp.data);
				sends_left--;
				taken_cnt++;
				lcg_state = lcg_next(lcg_state);
			end
			in_smp.vld  = (sends_left > 0);
			in_smp.data = lcg_state[31:16];
			beat_pend   = in_smp.vld && in_rdy;
		end
	end

	// samples near the middle of each bit
	task automatic rx_byte(output logic [7:0] b);
		do @(negedge clk_sys); while (uart_txd === 1'b1);
		repeat (`BR_BAUD_DIV / 2) @(negedge clk_sys);
		check_equal("uart start bit", 32'd0, uart_txd);
		for (int i = 0; i < 8; i++) begin
			repeat (`BR_BAUD_DIV) @(negedge clk_sys);
			b[i] = uart_txd;
		end
		repeat (`BR_BAUD_DIV) @(negedge clk_sys);
		check_equal("uart stop bit", 32'd1, uart_txd);
	endtask

	initial begin
		logic [7:0] lo;
		logic [7:0] hi;
		wait (rst_n === 1'b1);
		forever begin
			rx_byte(lo);
			rx_byte(hi);
			if (exp_q.size() == 0) begin
				$display("a word arrived on uart_txd with no accepted sample waiting for it");
				$display("*** FAILED ***");
				$fatal(1, "unexpected uart word");
			end else begin
				check_equal("uart word", exp_q.pop_front(), {hi, lo});
				words_rx++;
			end
		end
	end

	// ------------------------------------------------------------
	// timeout
	// ------------------------------------------------------------

	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("*** FAILED ***");
			$fatal(1, "timeout");
		end
	end

	// ------------------------------------------------------------
	// block sequences
	// ------------------------------------------------------------

	// poll status until the next block is counted, then check words and busy
	task automatic await_block(input int blk_words, input logic busy_after);
		logic [15:0] rd;
		do read_reg(2'(`BR_REG_STATUS), rd); while (rd[15:1] != done_cnt + 15'd1);
		done_cnt++;
		words_exp += blk_words;
		check_equal("words on uart_txd", words_exp, words_rx);
		read_reg(2'(`BR_REG_STATUS), rd);
		check_equal("status after block", {done_cnt, busy_after}, rd);
	endtask

	task automatic run_row(input row_t row);
		logic [15:0] rd;
		int          start;
		write_reg(2'(`BR_REG_LEN), row.len_wr);
		read_reg(2'(`BR_REG_LEN), rd);
		check_equal("length readback", row.len_exp, rd);
		wait (sends_left == 0);
		start      = taken_cnt;
		// the mid-drain row offers one extra sample that must wait for the next block
		sends_left = row.len_exp + (row.mid_wr ? 1 : 0);
		wait (taken_cnt == start + row.len_exp);
		check_equal("in_rdy after last sample", 32'd0, in_rdy);
		read_reg(2'(`BR_REG_STATUS), rd);
		check_equal("status during block", {done_cnt, 1'b1}, rd);
		if (row.mid_wr) begin
			write_reg(2'(`BR_REG_LEN), 16'(MID_LEN));
			read_reg(2'(`BR_REG_LEN), rd);
			check_equal("length written during drain", MID_LEN, rd);
		end
		await_block(row.len_exp, row.mid_wr);
	endtask

	initial begin
		logic [15:0] rd;
		int          total;
		wb_req     = '0;
		in_smp     = '0;
		rst_n      = 1'b0;
		lcg_state  = 32'h825b;
		beat_pend  = 1'b0;
		done_cnt   = '0;
		sends_left = 0;
		taken_cnt  = 0;
		words_rx   = 0;
		words_exp  = 0;
		cycle_cnt  = 0;

		rows[0] = '{16'd5, 16'd5, 1'b0};
		rows[1] = '{16'd0, 16'd1, 1'b0};
		rows[2] = '{16'd64, 16'd64, 1'b0};
		rows[3] = '{16'd200, 16'd64, 1'b0};
		rows[4] = '{16'd3, 16'd3, 1'b1};

		// every word costs 20 bit times on the line
		total = MID_LEN;
		for (int i = 0; i < NUM_ROWS; i++) begin
			total += rows[i].len_exp;
		end
		cycle_limit = total * 20 * `BR_BAUD_DIV + 4000;

		repeat (8) @(negedge clk_sys);
		rst_n = 1'b1;

		// idle state right after reset
		@(negedge clk_sys);
		check_equal("uart_txd", 32'd1, uart_txd);
		check_equal("wb_rsp.ack", 32'd0, wb_rsp.ack);
		check_equal("in_rdy", 32'd1, in_rdy);
		read_reg(2'(`BR_REG_STATUS), rd);
		check_equal("status after reset", 32'd0, rd);

		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(rows[i]);
		end

		// the carried sample opened a block of MID_LEN and one more closes it
		wait (sends_left == 0);
		sends_left = MID_LEN - 1;
		await_block(MID_LEN, 1'b0);
		check_equal("samples left unsent", 32'd0, exp_q.size());

		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- block_relay.f
+incdir+include
logic/block_relay_pkg.sv
logic/sample_fifo.sv
logic/block_sequencer.sv
logic/uart_word_tx.sv
logic/relay_regs.sv
logic/block_relay_top.sv
bench/block_relay_tb.sv

//--- include/block_relay_defs.svh
// build constants for the block relay; FIFO depth must be a power of two and fit in BR_LEN_W bits
`ifndef BLOCK_RELAY_DEFS_SVH
`define BLOCK_RELAY_DEFS_SVH

// ------------------------------------------------------------
// sample buffer
// ------------------------------------------------------------

// words held by the sample FIFO and so the longest block
`define BR_FIFO_DEPTH 64

// width of length and count fields that still holds the depth itself
`define BR_LEN_W 7

// block length after reset
`define BR_LEN_RESET 10

// ------------------------------------------------------------
// serial line and register map
// ------------------------------------------------------------

// clock cycles per uart bit
`define BR_BAUD_DIV 4

// wishbone word offsets
`define BR_REG_LEN 0
`define BR_REG_STATUS 1

`endif

//--- logic/block_relay_pkg.sv
// shared types for the block relay; wishbone data is 16 bits and the word address is 2 bits wide
package block_relay_pkg;

	// ------------------------------------------------------------
	// state machines
	// ------------------------------------------------------------

	// block cycle of filling, draining, reporting and reopening
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_FILL,
		SEQ_DRAIN,
		SEQ_CLOSE
	} seq_state_e;

	// one 8N1 frame that runs twice per word
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	// ------------------------------------------------------------
	// bus and stream beats
	// ------------------------------------------------------------

	// wishbone classic request
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [1:0]  adr;
		logic [15:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [15:0] dat;
	} wb_rsp_t;

	// sample input beat whose ready travels the other way
	typedef struct packed {
		logic        vld;
		logic [15:0] data;
	} sample_t;

endpackage

//--- logic/block_relay_top.sv
// block relay top; one clock domain, samples are 16 bits and leave on uart_txd low byte first
`include "block_relay_defs.svh"

module block_relay_top import block_relay_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst_n,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	input  sample_t in_smp,
	output logic    in_rdy,
	output logic    uart_txd
);

	logic [`BR_LEN_W-1:0] blk_len;
	logic                 blk_done;
	logic                 busy;
	logic                 fifo_wr;
	logic                 fifo_rd;
	logic [15:0]          head_data;
	logic                 word_vld;
	logic                 word_rdy;

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------

	relay_regs u_regs (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp),
		.blk_len  (blk_len),
		.blk_done (blk_done),
		.busy     (busy)
	);

	block_sequencer u_seq (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.in_vld   (in_smp.vld),
		.in_rdy   (in_rdy),
		.blk_len  (blk_len),
		.fifo_wr  (fifo_wr),
		.fifo_rd  (fifo_rd),
		.word_vld (word_vld),
		.word_rdy (word_rdy),
		.blk_done (blk_done),
		.busy     (busy)
	);

	// ------------------------------------------------------------
	// data path
	// ------------------------------------------------------------

	// sample data goes straight into the buffer
	sample_fifo u_fifo (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.wr      (fifo_wr),
		.wr_data (in_smp.data),
		.rd      (fifo_rd),
		.rd_data (head_data)
	);

	uart_word_tx u_tx (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.word_vld  (word_vld),
		.word_data (head_data),
		.word_rdy  (word_rdy),
		.txd       (uart_txd)
	);

endmodule

//--- logic/block_sequencer.sv
// block control for the relay; blk_len must lie in 1..BR_FIFO_DEPTH
`include "block_relay_defs.svh"

module block_sequencer import block_relay_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 in_vld,
	output logic                 in_rdy,
	input  logic [`BR_LEN_W-1:0] blk_len,
	output logic                 fifo_wr,
	output logic                 fifo_rd,
	output logic                 word_vld,
	input  logic                 word_rdy,
	output logic                 blk_done,
	output logic                 busy
);

	seq_state_e           state;
	logic [`BR_LEN_W-1:0] len_q;
	logic [`BR_LEN_W-1:0] fill_cnt;
	logic [`BR_LEN_W-1:0] drain_cnt;
	logic                 accept;
	logic                 handover;
	logic                 fill_last;
	logic                 drain_end;

	// ------------------------------------------------------------
	// handshakes
	// ------------------------------------------------------------

	// input open only before the block is complete
	assign in_rdy   = (state == SEQ_IDLE) || (state == SEQ_FILL);
	assign accept   = in_vld && in_rdy;
	assign fifo_wr  = accept;

	// offer words until the latched length has been handed over
	assign word_vld = (state == SEQ_DRAIN) && (drain_cnt != len_q);
	assign handover = word_vld && word_rdy;
	assign fifo_rd  = handover;

	// idle accepts the first sample so a length of one ends there
	assign fill_last = (state == SEQ_IDLE) ? (blk_len == `BR_LEN_W'(1))
		: (fill_cnt + `BR_LEN_W'(1) == len_q);

	// last word gone and the line back to idle
	assign drain_end = (state == SEQ_DRAIN) && (drain_cnt == len_q) && word_rdy;

	assign blk_done = (state == SEQ_CLOSE);
	assign busy     = (state != SEQ_IDLE);

	// ------------------------------------------------------------
	// block FSM
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= SEQ_IDLE;
			len_q <= '0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (accept) begin
						// length frozen here so later writes wait for the next block
						len_q <= blk_len;
						state <= fill_last ? SEQ_DRAIN : SEQ_FILL;
					end
				end
				SEQ_FILL: begin
					if (accept && fill_last) begin
						state <= SEQ_DRAIN;
					end
				end
				SEQ_DRAIN: begin
					if (drain_end) begin
						state <= SEQ_CLOSE;
					end
				end
				SEQ_CLOSE: begin
					state <= SEQ_IDLE;
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// progress counters
	// ------------------------------------------------------------

	// counts every accepted sample including the first
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			fill_cnt <= '0;
		end else if (accept) begin
			fill_cnt <= (state == SEQ_IDLE) ? `BR_LEN_W'(1) : fill_cnt + `BR_LEN_W'(1);
		end else if (state == SEQ_CLOSE) begin
			fill_cnt <= '0;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			drain_cnt <= '0;
		end else if (handover) begin
			drain_cnt <= drain_cnt + `BR_LEN_W'(1);
		end else if (state == SEQ_CLOSE) begin
			drain_cnt <= '0;
		end
	end

endmodule

//--- logic/relay_regs.sv
// wishbone classic slave; cyc and stb stay high until ack and unmapped offsets read zero
`include "block_relay_defs.svh"

module relay_regs import block_relay_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  wb_req_t              wb_req,
	output wb_rsp_t              wb_rsp,
	output logic [`BR_LEN_W-1:0] blk_len,
	input  logic                 blk_done,
	input  logic                 busy
);

	logic                 req;
	logic                 take;
	logic                 ack_q;
	logic                 served;
	logic [`BR_LEN_W-1:0] len_q;
	logic [`BR_LEN_W-1:0] len_clamped;
	logic [14:0]          blk_cnt;

	// ------------------------------------------------------------
	// bus handshake
	// ------------------------------------------------------------

	assign req  = wb_req.cyc && wb_req.stb;
	assign take = req && !ack_q && !served;

	// one ack per strobe; served holds it off until stb drops
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ack_q  <= 1'b0;
			served <= 1'b0;
		end else begin
			ack_q <= take;
			if (!req) begin
				served <= 1'b0;
			end else if (ack_q) begin
				served <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// registers
	// ------------------------------------------------------------

	// length limited to 1..depth
	always_comb begin
		if (wb_req.dat == 16'd0) begin
			len_clamped = `BR_LEN_W'(1);
		end else if (wb_req.dat > 16'(`BR_FIFO_DEPTH)) begin
			len_clamped = `BR_LEN_W'(`BR_FIFO_DEPTH);
		end else begin
			len_clamped = wb_req.dat[`BR_LEN_W-1:0];
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			len_q <= `BR_LEN_W'(`BR_LEN_RESET);
		end else if (take && wb_req.we && wb_req.adr == 2'(`BR_REG_LEN)) begin
			len_q <= len_clamped;
		end
	end

	// finished block count wrapping at 2^15
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			blk_cnt <= '0;
		end else if (blk_done) begin
			blk_cnt <= blk_cnt + 15'd1;
		end
	end

	assign blk_len = len_q;

	// ------------------------------------------------------------
	// read path
	// ------------------------------------------------------------

	always_comb begin
		wb_rsp.ack = ack_q;
		case (wb_req.adr)
			2'(`BR_REG_LEN):    wb_rsp.dat = 16'(len_q);
			2'(`BR_REG_STATUS): wb_rsp.dat = {blk_cnt, busy};
			default:            wb_rsp.dat = 16'h0000;
		endcase
	end

endmodule

//--- logic/sample_fifo.sv
// fall-through sample buffer without flags; a block must never exceed BR_FIFO_DEPTH words
`include "block_relay_defs.svh"

module sample_fifo (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        wr,
	input  logic [15:0] wr_data,
	input  logic        rd,
	output logic [15:0] rd_data
);

	localparam int PTR_W = $clog2(`BR_FIFO_DEPTH);

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------

	logic [15:0]      mem [0:`BR_FIFO_DEPTH-1];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// word storage written at the tail
	always_ff @(posedge clk_sys) begin
		if (wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// ------------------------------------------------------------
	// pointers
	// ------------------------------------------------------------

	// depth is a power of two so both pointers wrap by overflow
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (wr) begin
			wr_ptr <= wr_ptr + PTR_W'(1);
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (rd) begin
			rd_ptr <= rd_ptr + PTR_W'(1);
		end
	end

	// head word shows a write one cycle later
	assign rd_data = mem[rd_ptr];

endmodule

//--- logic/uart_word_tx.sv
// 8N1 word serializer; low byte first, no parity or flow control, one idle cycle between words
`include "block_relay_defs.svh"

module uart_word_tx import block_relay_pkg::*; (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        word_vld,
	input  logic [15:0] word_data,
	output logic        word_rdy,
	output logic        txd
);

	localparam int BAUD_W = ($clog2(`BR_BAUD_DIV) > 0) ? $clog2(`BR_BAUD_DIV) : 1;

	tx_state_e         state;
	logic [BAUD_W-1:0] baud_cnt;
	logic [2:0]        bit_cnt;
	logic              byte_idx;
	logic [15:0]       shreg;
	logic              baud_tick;
	logic              handover;

	assign word_rdy  = (state == TX_IDLE);
	assign handover  = word_vld && word_rdy;
	assign baud_tick = (baud_cnt == BAUD_W'(`BR_BAUD_DIV - 1));

	// ------------------------------------------------------------
	// bit timing
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			baud_cnt <= '0;
		end else if (state == TX_IDLE || baud_tick) begin
			baud_cnt <= '0;
		end else begin
			baud_cnt <= baud_cnt + BAUD_W'(1);
		end
	end

	// ------------------------------------------------------------
	// frame FSM
	// ------------------------------------------------------------

	// txd is registered and changes on the same edges as the state
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state    <= TX_IDLE;
			bit_cnt  <= '0;
			byte_idx <= 1'b0;
			txd      <= 1'b1;
		end else begin
			case (state)
				TX_IDLE: begin
					txd <= 1'b1;
					if (handover) begin
						byte_idx <= 1'b0;
						state    <= TX_START;
						txd      <= 1'b0;
					end
				end
				TX_START: begin
					if (baud_tick) begin
						bit_cnt <= '0;
						state   <= TX_DATA;
						txd     <= shreg[0];
					end
				end
				TX_DATA: begin
					if (baud_tick) begin
						if (bit_cnt == 3'd7) begin
							state <= TX_STOP;
							txd   <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 3'd1;
							txd     <= shreg[1];
						end
					end
				end
				TX_STOP: begin
					if (baud_tick) begin
						if (!byte_idx) begin
							// high byte follows without a gap
							byte_idx <= 1'b1;
							state    <= TX_START;
							txd      <= 1'b0;
						end else begin
							state <= TX_IDLE;
						end
					end
				end
				default: begin
					state <= TX_IDLE;
					txd   <= 1'b1;
				end
			endcase
		end
	end

	// lsb first; after eight shifts the high byte sits in the low half
	always_ff @(posedge clk_sys) begin
		if (handover) begin
			shreg <= word_data;
		end else if (state == TX_DATA && baud_tick) begin
			shreg <= shreg >> 1;
		end
	end

endmodule
